//--- build.f
+incdir+include
src/mm_pkg.sv
src/mm_pe.sv
src/mm_operand_feeder.sv
src/mm_systolic_array.sv
src/mm_top.sv
test/tb_mm_top.sv

//--- include/mm_settings.svh
// Matrix multiplier settings
// Array size and Q8.8 fixed-point widths shared by all blocks

`ifndef MM_SETTINGS_SVH
`define MM_SETTINGS_SVH

// Array dimension, rows and columns alike
`define MM_DIM 2

// Element width of A, B and the results
`define MM_DATA_W 16

// Fraction bits of the Q8.8 format
`define MM_FRAC_W 8

// PE accumulator, holds a full 16x16 signed product sum
`define MM_ACC_W 32

`endif

//--- run.sh
#!/bin/sh
# Build and run the matrix multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mm_top -f build.f

# The simulation result is judged from the log below
./obj_dir/Vtb_mm_top > sim.log 2>&1 || true
cat sim.log

if grep -q "^all tests passed$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- src/mm_operand_feeder.sv
// Operand feeder
// Holds one 2x2 operand set and streams it as two skewed lanes on launch

`timescale 1ns/1ps
`include "mm_settings.svh"

module mm_operand_feeder #(
    parameter type elem_t = logic signed [`MM_DATA_W-1:0]
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  logic             launch,
    input  elem_t [1:0][1:0] mat_in,
    output elem_t            lane0,
    output elem_t            lane1
);

    // Indexed [lane][element]
    elem_t [1:0][1:0] mat_q;
    elem_t [1:0][1:0] run_q;

    // 0 idle, 1..3 lane steps of a run
    logic [1:0] phase;

    // Host copy, may change while a run is going
    always_ff @(posedge clk) begin
        if (load) begin
            mat_q <= mat_in;
        end
    end

    // Working copy for the run, frozen at launch
    // A load in the launch cycle counts for the following run
    always_ff @(posedge clk) begin
        if (launch) begin
            run_q <= mat_q;
        end
    end

    // Skewed lane sequence
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= 2'd0;
            lane0 <= '0;
            lane1 <= '0;
        end else if (launch) begin
            phase <= 2'd1;
            lane0 <= mat_q[0][0];
            lane1 <= '0;
        end else begin
            case (phase)
                2'd1: begin
                    phase <= 2'd2;
                    lane0 <= run_q[0][1];
                    lane1 <= run_q[1][0];
                end
                2'd2: begin
                    phase <= 2'd3;
                    lane0 <= '0;
                    lane1 <= run_q[1][1];
                end
                default: begin
                    phase <= 2'd0;
                    lane0 <= '0;
                    lane1 <= '0;
                end
            endcase
        end
    end

endmodule

//--- src/mm_pe.sv
// Systolic processing element
// Multiply-accumulate of the west and north operands, which move on east and south

`timescale 1ns/1ps
`include "mm_settings.svh"

module mm_pe (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clr,
    input  mm_pkg::a_elem_t in_west,
    input  mm_pkg::b_elem_t in_north,
    output mm_pkg::a_elem_t out_east,
    output mm_pkg::b_elem_t out_south,
    output mm_pkg::a_elem_t result
);

    logic signed [2*`MM_DATA_W-1:0] product;
    logic signed [`MM_ACC_W-1:0]    acc;

    // Full-width signed product, Q16.16
    assign product = in_west * in_north;

    // Operands hop one PE per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_east  <= '0;
            out_south <= '0;
        end else begin
            out_east  <= in_west;
            out_south <= in_north;
        end
    end

    // Accumulator
    // Zero operands outside the active window add nothing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (clr) begin
            acc <= '0;
        end else begin
            acc <= acc + product;
        end
    end

    // Back to Q8.8
    // Drop the extra fraction bits, keep the low 16 bits, wrap on overflow
    assign result = acc[`MM_FRAC_W +: `MM_DATA_W];

endmodule

//--- src/mm_pkg.sv
// Matrix multiplier types
// Q8.8 elements and the packed operand and result sets

`include "mm_settings.svh"

package mm_pkg;

    // Signed Q8.8 elements
    typedef logic signed [`MM_DATA_W-1:0] a_elem_t;
    typedef logic signed [`MM_DATA_W-1:0] b_elem_t;

    // Matrix A, row-major
    // a00 sits in the low bits, so that the feeder index [lane][elem] is [row][col]
    typedef struct packed {
        a_elem_t a11;
        a_elem_t a10;
        a_elem_t a01;
        a_elem_t a00;
    } a_rows_t;

    // Matrix B, column-major
    // Feeder index [lane][elem] is [col][row]
    typedef struct packed {
        b_elem_t b11;
        b_elem_t b01;
        b_elem_t b10;
        b_elem_t b00;
    } b_cols_t;

    // Q8.8 products, c00 in the top bits
    typedef struct packed {
        a_elem_t c00;
        a_elem_t c01;
        a_elem_t c10;
        a_elem_t c11;
    } result_t;

endpackage

//--- src/mm_systolic_array.sv
// 2x2 output-stationary systolic array
// Four PEs plus the run sequencer that issues launch, clear and done

`timescale 1ns/1ps
`include "mm_settings.svh"

module mm_systolic_array (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  mm_pkg::a_elem_t a_west0,
    input  mm_pkg::a_elem_t a_west1,
    input  mm_pkg::b_elem_t b_north0,
    input  mm_pkg::b_elem_t b_north1,
    output logic            launch,
    output logic            done,
    output mm_pkg::result_t result
);

    // Last product lands in the far corner PE at cycle 3*DIM-2
    // Count runs from 0 in cycle 1, so done is set one cycle later
    localparam logic [2:0] LAST_COUNT = 3'(3 * `MM_DIM - 3);

    logic       busy;
    logic [2:0] count;

    // Links between PEs
    mm_pkg::a_elem_t east00;
    mm_pkg::a_elem_t east10;
    mm_pkg::b_elem_t south00;
    mm_pkg::b_elem_t south01;

    mm_pkg::a_elem_t r00;
    mm_pkg::a_elem_t r01;
    mm_pkg::a_elem_t r10;
    mm_pkg::a_elem_t r11;

    mm_pkg::result_t pe_result;
    mm_pkg::result_t result_q;

    // Start is taken only when idle
    assign launch = start & ~busy;

    // Row 0
    mm_pe pe00 (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (launch),
        .in_west   (a_west0),
        .in_north  (b_north0),
        .out_east  (east00),
        .out_south (south00),
        .result    (r00)
    );

    mm_pe pe01 (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (launch),
        .in_west   (east00),
        .in_north  (b_north1),
        .out_east  (),
        .out_south (south01),
        .result    (r01)
    );

    // Row 1
    mm_pe pe10 (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (launch),
        .in_west   (a_west1),
        .in_north  (south00),
        .out_east  (east10),
        .out_south (),
        .result    (r10)
    );

    mm_pe pe11 (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (launch),
        .in_west   (east10),
        .in_north  (south01),
        .out_east  (),
        .out_south (),
        .result    (r11)
    );

    // Run sequencer, count to done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                if (count == LAST_COUNT) begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    count <= '0;
                end else begin
                    count <= count + 3'd1;
                end
            end
        end
    end

    assign pe_result.c00 = r00;
    assign pe_result.c01 = r01;
    assign pe_result.c10 = r10;
    assign pe_result.c11 = r11;

    // Hold the finished products until the next run completes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
        end else if (done) begin
            result_q <= pe_result;
        end
    end

    // Live PE values in the done cycle, held copy afterwards
    assign result = done ? pe_result : result_q;

endmodule

//--- src/mm_top.sv
// Fixed-point 2x2 matrix multiplier
// A and B feeders side by side, combined in the systolic array

`timescale 1ns/1ps
`include "mm_settings.svh"

module mm_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  logic            start,
    input  mm_pkg::a_rows_t a_in,
    input  mm_pkg::b_cols_t b_in,
    output logic            done,
    output mm_pkg::result_t result
);

    logic            launch;
    mm_pkg::a_elem_t a_west0;
    mm_pkg::a_elem_t a_west1;
    mm_pkg::b_elem_t b_north0;
    mm_pkg::b_elem_t b_north1;

    // Rows of A enter from the west
    mm_operand_feeder #(
        .elem_t (mm_pkg::a_elem_t)
    ) u_feed_a (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .launch (launch),
        .mat_in (a_in),
        .lane0  (a_west0),
        .lane1  (a_west1)
    );

    // Columns of B enter from the north
    mm_operand_feeder #(
        .elem_t (mm_pkg::b_elem_t)
    ) u_feed_b (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .launch (launch),
        .mat_in (b_in),
        .lane0  (b_north0),
        .lane1  (b_north1)
    );

    mm_systolic_array u_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .a_west0  (a_west0),
        .a_west1  (a_west1),
        .b_north0 (b_north0),
        .b_north1 (b_north1),
        .launch   (launch),
        .done     (done),
        .result   (result)
    );

endmodule

//--- test/mm_testdata.txt
// Record count, then one record per line, every word a Q8.8 value in hex
// a00 a01 a10 a11  b00 b01 b10 b11  c00 c01 c10 c11
0010
// Identity and plain integers
0100 0000 0000 0100  0100 0000 0000 0100  0100 0000 0000 0100
0100 0000 0000 0100  0100 0200 0300 0400  0100 0200 0300 0400
0100 0200 0300 0400  0500 0600 0700 0800  1300 1600 2b00 3200
0100 0100 0100 0100  0101 00ff 0001 7f00  0102 7fff 0102 7fff
0000 0000 0000 0000  1234 5678 9abc def0  0000 0000 0000 0000
// Signed operands
ff00 0200 0300 fc00  0100 ff00 fe00 0200  fb00 0500 0b00 f500
0200 fd00 0080 0100  ff00 0080 0200 fe00  f800 0700 0180 fe40
0300 0400 fb00 0600  0200 ff80 0080 0100  0800 0280 f900 0880
// Fractions and truncation toward minus infinity
0080 0040 0180 ff80  0080 0200 0400 ffc0  0140 00f0 fec0 0320
0001 0001 0003 ffff  0001 0080 0010 00ff  0000 0001 ffff 0000
0133 00cd fecd 0055  0155 0011 0022 ff00  01b4 ff47 fe72 ff96
ffff 0000 0000 ffff  0001 0000 0000 0001  ffff 0000 0000 ffff
0010 fff0 0008 0004  0020 0040 0010 ffe0  0001 0006 0001 0001
// Wrap of the 16-bit result
4000 4000 7fff 8000  0400 0200 0400 7fff  0000 7fc0 fffc 007e
8000 0000 0000 8000  8000 0100 ff00 8000  0000 8000 8000 0000
7f00 7f00 0100 ff00  0100 0200 0100 0100  fe00 7d00 0000 0100

//--- test/tb_mm_top.sv
// Testbench for the 2x2 Q8.8 matrix multiplier
// File vectors, run-control cases and random runs checked against a reference model

`timescale 1ns/1ps
`include "mm_settings.svh"

module tb_mm_top;

    localparam int WORDS_PER_VEC = 12;
    localparam int MAX_VECS      = 64;
    localparam int DONE_LATENCY  = 5;
    localparam int WAIT_LIMIT    = 40;
    localparam int HOLD_CYCLES   = 4;
    localparam int RANDOM_RUNS   = 50;
    localparam int SIM_LIMIT     = 20000;

    logic            clk;
    logic            rst_n;
    logic            load;
    logic            start;
    mm_pkg::a_rows_t a_in;
    mm_pkg::b_cols_t b_in;
    logic            done;
    mm_pkg::result_t result;

    // Word 0 holds the record count, records follow
    logic [`MM_DATA_W-1:0] vec_mem [0:WORDS_PER_VEC*MAX_VECS];
    logic [31:0]           rng_state;

    mm_top u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .start  (start),
        .a_in   (a_in),
        .b_in   (b_in),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    // Overall cycle limit
    initial begin
        repeat (SIM_LIMIT) @(posedge clk);
        abort_run("simulation ran past its overall cycle limit");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One Q8.8 dot product term pair
    // Full sum, arithmetic shift by the fraction width, low 16 bits kept
    function automatic mm_pkg::a_elem_t q88_dot(input mm_pkg::a_elem_t x0,
                                                input mm_pkg::b_elem_t y0,
                                                input mm_pkg::a_elem_t x1,
                                                input mm_pkg::b_elem_t y1);
        longint sum;
        longint shifted;
        sum     = longint'(x0) * longint'(y0) + longint'(x1) * longint'(y1);
        shifted = sum >>> `MM_FRAC_W;
        return shifted[`MM_DATA_W-1:0];
    endfunction

    function automatic mm_pkg::result_t expected_result(input mm_pkg::a_rows_t a,
                                                        input mm_pkg::b_cols_t b);
        mm_pkg::result_t r;
        r.c00 = q88_dot(a.a00, b.b00, a.a01, b.b10);
        r.c01 = q88_dot(a.a00, b.b01, a.a01, b.b11);
        r.c10 = q88_dot(a.a10, b.b00, a.a11, b.b10);
        r.c11 = q88_dot(a.a10, b.b01, a.a11, b.b11);
        return r;
    endfunction

    task automatic random_operands(output mm_pkg::a_rows_t a, output mm_pkg::b_cols_t b);
        rng_state = xorshift32(rng_state);
        a.a00     = rng_state[15:0];
        a.a01     = rng_state[31:16];
        rng_state = xorshift32(rng_state);
        a.a10     = rng_state[15:0];
        a.a11     = rng_state[31:16];
        rng_state = xorshift32(rng_state);
        b.b00     = rng_state[15:0];
        b.b01     = rng_state[31:16];
        rng_state = xorshift32(rng_state);
        b.b10     = rng_state[15:0];
        b.b11     = rng_state[31:16];
    endtask

    task automatic check_result(input mm_pkg::result_t got, input mm_pkg::result_t want,
                                input string what);
        if (got !== want) begin
            abort_run($sformatf("Error result %s: got %h expected %h", what, got, want));
        end
    endtask

    task automatic check_done(input logic want, input string what);
        if (done !== want) begin
            abort_run($sformatf("Error done %s: got %h expected %h", what, done, want));
        end
    endtask

    task automatic check_latency(input int got, input int want, input string what);
        if (got != want) begin
            abort_run($sformatf("Error done latency %s: got %0h expected %0h cycles",
                                what, got, want));
        end
    endtask

    task automatic load_matrices(input mm_pkg::a_rows_t a, input mm_pkg::b_cols_t b);
        @(posedge clk);
        load <= 1'b1;
        a_in <= a;
        b_in <= b;
        @(posedge clk);
        load <= 1'b0;
    endtask

    // Returns on the edge where the DUT samples start
    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Counts falling edges until done shows up
    task automatic wait_for_done(output int cycles);
        int n;
        n      = 0;
        cycles = 0;
        while (cycles == 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (done === 1'b1) begin
                cycles = n;
            end
        end
        if (cycles == 0) begin
            abort_run("done never came after an accepted start");
        end
    endtask

    // Single-cycle done, result held afterwards
    task automatic check_hold(input mm_pkg::result_t want, input int hold, input string what);
        int n;
        for (n = 0; n < hold; n++) begin
            @(negedge clk);
            check_done(1'b0, {what, " after pulse"});
            check_result(result, want, {what, " held"});
        end
    endtask

    task automatic run_loaded(input mm_pkg::result_t want, input int hold, input string what);
        int cycles;
        pulse_start();
        wait_for_done(cycles);
        check_latency(cycles, DONE_LATENCY, what);
        check_result(result, want, what);
        check_hold(want, hold, what);
    endtask

    task automatic run_and_check(input mm_pkg::a_rows_t a, input mm_pkg::b_cols_t b,
                                 input mm_pkg::result_t want, input int hold,
                                 input string what);
        load_matrices(a, b);
        run_loaded(want, hold, what);
    endtask

    initial begin
        mm_pkg::a_rows_t a;
        mm_pkg::a_rows_t a2;
        mm_pkg::b_cols_t b;
        mm_pkg::b_cols_t b2;
        mm_pkg::result_t want;
        int num_vecs;
        int base;
        int cycles;
        int v;

        rst_n     = 1'b0;
        load      = 1'b0;
        start     = 1'b0;
        a_in      = '0;
        b_in      = '0;
        rng_state = 32'h52ec8550;
        $readmemh("test/mm_testdata.txt", vec_mem);
        num_vecs = int'(vec_mem[0]);
        if (num_vecs == 0 || num_vecs > MAX_VECS) begin
            abort_run("test vector file is empty or holds too many records");
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Idle outputs after reset
        check_hold('0, HOLD_CYCLES + 1, "after reset");

        // File vectors
        for (v = 0; v < num_vecs; v++) begin
            base    = 1 + v * WORDS_PER_VEC;
            a.a00   = vec_mem[base];
            a.a01   = vec_mem[base + 1];
            a.a10   = vec_mem[base + 2];
            a.a11   = vec_mem[base + 3];
            b.b00   = vec_mem[base + 4];
            b.b01   = vec_mem[base + 5];
            b.b10   = vec_mem[base + 6];
            b.b11   = vec_mem[base + 7];
            want.c00 = vec_mem[base + 8];
            want.c01 = vec_mem[base + 9];
            want.c10 = vec_mem[base + 10];
            want.c11 = vec_mem[base + 11];
            run_and_check(a, b, want, HOLD_CYCLES, $sformatf("vector %0d", v));
        end

        // Second start while busy, sampled two cycles after the first
        random_operands(a, b);
        want = expected_result(a, b);
        load_matrices(a, b);
        pulse_start();
        pulse_start();
        wait_for_done(cycles);
        check_latency(cycles + 2, DONE_LATENCY, "with ignored start");
        check_result(result, want, "with ignored start");
        check_hold(want, 2 * HOLD_CYCLES, "with ignored start");

        // New operands sampled one cycle into a run, while the lanes still stream
        random_operands(a, b);
        random_operands(a2, b2);
        load_matrices(a, b);
        pulse_start();
        load <= 1'b1;
        a_in <= a2;
        b_in <= b2;
        @(posedge clk);
        load <= 1'b0;
        wait_for_done(cycles);
        check_latency(cycles + 1, DONE_LATENCY, "with load during run");
        check_result(result, expected_result(a, b), "with load during run");
        check_hold(expected_result(a, b), HOLD_CYCLES, "with load during run");
        run_loaded(expected_result(a2, b2), HOLD_CYCLES, "run after load during run");

        // Back-to-back random runs
        for (v = 0; v < RANDOM_RUNS; v++) begin
            random_operands(a, b);
            run_and_check(a, b, expected_result(a, b), 0, $sformatf("random run %0d", v));
        end

        $display("all tests passed");
        $finish;
    end

endmodule
